// File: Bender.yml
package:
  name: cnn_top

sources:
  - common/cnn_pkg.sv
  - cache/act_cache.sv
  - cache/weight_cache.sv
  - pe/conv_pe.sv
  - pool/max_pool.sv
  - hdl/cnn_ctrl.sv
  - hdl/cnn_top.sv
  - target: simulation
    files:
      - dv/cnn_tb.sv

// File: cache/act_cache.sv
`timescale 1ns/1ps
`default_nettype none

module act_cache (
  input  logic                clk,
  input  logic                rst,
  input  cnn_pkg::fill_t      i_fill,
  input  cnn_pkg::word_t      i_rdata,
  input  cnn_pkg::tile_req_t  i_tile,
  output cnn_pkg::patch_t     o_patch
);

  cnn_pkg::act_t win [cnn_pkg::WIN_ROWS*cnn_pkg::WIN_COLS];  // row major, 8 per row
  cnn_pkg::act_t [cnn_pkg::KERNEL_TAPS-1:0] patch_px;
  logic       patch_vld;
  logic [5:0] base;
  logic       row_off;
  logic [1:0] col_off;

  assign base    = {i_fill.idx[3:0], 2'b00};
  assign row_off = i_tile.tile[1];
  assign col_off = {i_tile.group, i_tile.tile[0]};  // group 1 shifts two columns

  always_ff @(posedge clk) begin
    if (i_fill.act_wr) begin
      for (int b = 0; b < 4; b++) begin
        win[base + b] <= i_rdata[31-8*b -: 8];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_tile.valid) begin
      for (int r = 0; r < cnn_pkg::KERNEL_DIM; r++) begin
        for (int c = 0; c < cnn_pkg::KERNEL_DIM; c++) begin
          patch_px[r*cnn_pkg::KERNEL_DIM + c] <= win[(r + row_off)*cnn_pkg::WIN_COLS + c + col_off];
        end
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      patch_vld <= 1'b0;
    end else begin
      patch_vld <= i_tile.valid;
    end
  end

  assign o_patch.valid = patch_vld;
  assign o_patch.px    = patch_px;

  a_fill_idx: assert property (@(posedge clk) disable iff (rst)
    i_fill.act_wr |-> i_fill.idx < 6'(cnn_pkg::ACT_WORDS));

endmodule

`default_nettype wire

// File: cache/weight_cache.sv
`timescale 1ns/1ps
`default_nettype none

module weight_cache (
  input  logic                                                      clk,
  input  logic                                                      rst,
  input  cnn_pkg::fill_t                                            i_fill,
  input  cnn_pkg::word_t                                            i_rdata,
  output cnn_pkg::wgt_t [cnn_pkg::NUM_CH*cnn_pkg::KERNEL_TAPS-1:0]  o_weights
);

  logic [7:0] base;

  assign base = {i_fill.idx, 2'b00};  // byte offset of this word

  // channel n owns bytes 25n .. 25n+24
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      o_weights <= '0;
    end else if (i_fill.wgt_wr) begin
      for (int b = 0; b < 4; b++) begin
        o_weights[base + b] <= i_rdata[31-8*b -: 8];
      end
    end
  end

endmodule

`default_nettype wire

// File: cnn_top.f
common/cnn_pkg.sv
cache/act_cache.sv
cache/weight_cache.sv
pe/conv_pe.sv
pool/max_pool.sv
hdl/cnn_ctrl.sv
hdl/cnn_top.sv
dv/cnn_tb.sv

// File: common/cnn_pkg.sv
`default_nettype none

package cnn_pkg;

  localparam int KERNEL_DIM  = 5;
  localparam int KERNEL_TAPS = KERNEL_DIM * KERNEL_DIM;
  localparam int NUM_CH      = 8;   // output channels, one PE each
  localparam int WIN_ROWS    = 6;
  localparam int WIN_COLS    = 8;
  localparam int ACT_WORDS   = 12;  // 48 window bytes, 4 per word
  localparam int WGT_WORDS   = 50;  // 200 weight bytes
  localparam int RES_WORDS   = 4;
  localparam int POOL_SIZE   = 4;   // tiles in one 2x2 pooling group
  localparam int QUANT_SHIFT = 8;

  typedef logic [31:0]        word_t;  // byte 4k sits in the top byte of word k
  typedef logic [31:0]        addr_t;
  typedef logic [7:0]         act_t;
  typedef logic signed [7:0]  wgt_t;
  typedef logic signed [31:0] acc_t;

  typedef struct packed {
    logic       en;
    logic [3:0] we;
    addr_t      addr;
    word_t      wdata;
  } bram_req_t;

  // cache write strobes, one cycle behind the bram address
  typedef struct packed {
    logic       act_wr;
    logic       wgt_wr;
    logic [5:0] idx;
  } fill_t;

  typedef struct packed {
    logic       valid;
    logic       group;  // which pair of tile columns
    logic [1:0] tile;
  } tile_req_t;

  typedef struct packed {
    logic                     valid;
    act_t [KERNEL_TAPS-1:0]   px;
  } patch_t;

  typedef struct packed {
    logic valid;
    act_t q;
  } pe_res_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    TILE,
    DRAIN,
    POOL,
    WRITE,
    DONE
  } ctrl_state_t;

endpackage

`default_nettype wire

// File: dv/cnn_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_tb;

  localparam int CLK_NS      = 100;
  localparam int RESET_CYC   = 16;
  localparam int RUN_CYCLES  = 80;  // 70 active cycles per run plus slack
  localparam int NUM_RUNS    = 5;
  localparam int WATCHDOG_NS = (NUM_RUNS * RUN_CYCLES + 2 * RESET_CYC + 200) * 2 * CLK_NS;

  logic               clk;
  logic               rst;
  logic               i_start;
  cnn_pkg::word_t     act_rdata;
  cnn_pkg::word_t     wgt_rdata;
  cnn_pkg::bram_req_t act_req;
  cnn_pkg::bram_req_t wgt_req;
  cnn_pkg::bram_req_t res_req;
  logic               done;

  cnn_pkg::word_t act_mem   [cnn_pkg::ACT_WORDS];
  cnn_pkg::word_t wgt_mem   [cnn_pkg::WGT_WORDS];
  cnn_pkg::word_t res_mem   [cnn_pkg::RES_WORDS];
  cnn_pkg::word_t exp_words [cnn_pkg::RES_WORDS];
  logic           act_rd_q;
  logic           wgt_rd_q;
  cnn_pkg::addr_t act_addr_q;
  cnn_pkg::addr_t wgt_addr_q;
  int             wr_count;
  int             done_count;
  logic [3:0]     wr_mask;
  logic           prev_wr;
  cnn_pkg::addr_t prev_addr;
  logic           prev_done;
  int             value_errs;
  int             proto_errs;
  int             seed;

  cnn_top u_dut (
    .clk         (clk),
    .rst         (rst),
    .i_start     (i_start),
    .i_act_rdata (act_rdata),
    .i_wgt_rdata (wgt_rdata),
    .o_act_req   (act_req),
    .o_wgt_req   (wgt_req),
    .o_res_req   (res_req),
    .o_done      (done)
  );

  always #(CLK_NS / 2) clk = ~clk;

  // read ports answer one cycle after an enabled address
  always @(negedge clk) begin
    act_rdata  <= act_rd_q ? act_mem[act_addr_q] : '0;
    wgt_rdata  <= wgt_rd_q ? wgt_mem[wgt_addr_q] : '0;
    act_rd_q   <= act_req.en;
    act_addr_q <= act_req.addr;
    wgt_rd_q   <= wgt_req.en;
    wgt_addr_q <= wgt_req.addr;
  end

  // result port and done protocol
  always @(negedge clk) begin
    if (!rst) begin
      if ((|act_req.we) || (|wgt_req.we)) begin
        $display("write enable on a read-only port at %0t ns", $time);
        proto_errs++;
      end
      if (res_req.en) begin
        wr_count++;
        if (res_req.we != 4'hf || res_req.addr >= cnn_pkg::RES_WORDS) begin
          $display("result write at %0t ns has mask %b and address %0d, not a full word in 0-3",
                   $time, res_req.we, res_req.addr);
          proto_errs++;
        end else begin
          res_mem[res_req.addr] = res_req.wdata;
          wr_mask[res_req.addr[1:0]] = 1'b1;
        end
      end
      if (done) begin
        done_count++;
        if (prev_done || !(prev_wr && prev_addr == 3)) begin
          $display("done at %0t ns is not a single cycle right after the last result write",
                   $time);
          proto_errs++;
        end
      end
    end
    prev_wr   = res_req.en;
    prev_addr = res_req.addr;
    prev_done = done;
  end

  task automatic check_word(input cnn_pkg::word_t got, input cnn_pkg::word_t exp,
                            input string what);
    if (got !== exp) begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      value_errs++;
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      $display("ERR %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
      value_errs++;
    end
  endtask

  function automatic int active_strobes();
    return int'(act_req.en) + int'(wgt_req.en) + int'(res_req.en) + int'(|act_req.we)
         + int'(|wgt_req.we) + int'(|res_req.we) + int'(done);
  endfunction

  task automatic check_quiet(input int cycles, input string what);
    repeat (cycles) begin
      @(negedge clk);
      check_count(active_strobes(), 0, what);
    end
  endtask

  // byte j sits in word j/4 with the lowest byte index on top
  function automatic cnn_pkg::act_t act_byte(input int j);
    return act_mem[j / 4][31 - 8 * (j % 4) -: 8];
  endfunction

  function automatic cnn_pkg::wgt_t wgt_byte(input int j);
    return $signed(wgt_mem[j / 4][31 - 8 * (j % 4) -: 8]);
  endfunction

  task automatic fill_random();
    foreach (act_mem[i]) act_mem[i] = $random(seed);
    foreach (wgt_mem[i]) wgt_mem[i] = $random(seed);
  endtask

  // conv per tile, relu, shift, saturate, then max over the 2x2 group
  task automatic build_expected();
    int            sum;
    int            q;
    int            best;
    int            ro;
    int            co;
    cnn_pkg::act_t pooled [16];
    for (int g = 0; g < 2; g++) begin
      for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
        best = 0;
        for (int t = 0; t < 4; t++) begin
          ro  = t / 2;
          co  = 2 * g + t % 2;
          sum = 0;
          for (int r = 0; r < 5; r++) begin
            for (int c = 0; c < 5; c++) begin
              sum += int'(act_byte((r + ro) * 8 + c + co)) * int'(wgt_byte(ch * 25 + r * 5 + c));
            end
          end
          q = (sum < 0) ? 0 : sum / 256;
          if (q > 255) q = 255;
          if (q > best) best = q;
        end
        pooled[g * 8 + ch] = best[7:0];
      end
    end
    for (int k = 0; k < cnn_pkg::RES_WORDS; k++) begin
      exp_words[k] = {pooled[4 * k], pooled[4 * k + 1], pooled[4 * k + 2], pooled[4 * k + 3]};
    end
  endtask

  task automatic run_engine(input bit restart_mid);
    wr_count   = 0;
    done_count = 0;
    wr_mask    = '0;
    foreach (res_mem[k]) res_mem[k] = 'x;  // stale words must not pass
    @(negedge clk);
    i_start = 1'b1;
    @(negedge clk);
    i_start = 1'b0;
    if (restart_mid) begin
      repeat (20) @(negedge clk);
      i_start = 1'b1;  // lands in LOAD
      @(negedge clk);
      i_start = 1'b0;
    end
    while (!done) @(negedge clk);
    repeat (2) @(negedge clk);
    check_count(wr_count, cnn_pkg::RES_WORDS, "result writes in run");
    check_count(done_count, 1, "done pulses in run");
    check_count(int'(wr_mask), 15, "result address mask");
  endtask

  task automatic compare_results(input string what);
    for (int k = 0; k < cnn_pkg::RES_WORDS; k++) begin
      check_word(res_mem[k], exp_words[k], $sformatf("%s word %0d", what, k));
    end
  endtask

  task automatic test_known_pattern();
    foreach (act_mem[i]) act_mem[i] = 32'h1010_1010;
    foreach (wgt_mem[i]) wgt_mem[i] = 32'h0101_0101;
    run_engine(1'b0);
    for (int k = 0; k < cnn_pkg::RES_WORDS; k++) begin
      check_word(res_mem[k], 32'h0101_0101, $sformatf("known pattern word %0d", k));
    end
  endtask

  task automatic test_random_data();
    fill_random();
    build_expected();
    run_engine(1'b0);
    compare_results("random run");
  endtask

  // even channels all -128, odd channels all +127, every activation 255
  task automatic test_sign_saturation();
    int ch;
    foreach (act_mem[i]) act_mem[i] = '1;
    for (int j = 0; j < cnn_pkg::NUM_CH * cnn_pkg::KERNEL_TAPS; j++) begin
      ch = j / cnn_pkg::KERNEL_TAPS;
      wgt_mem[j / 4][31 - 8 * (j % 4) -: 8] = (ch % 2) ? 8'h7f : 8'h80;
    end
    run_engine(1'b0);
    for (int k = 0; k < cnn_pkg::RES_WORDS; k++) begin
      check_word(res_mem[k], 32'h00ff_00ff, $sformatf("sign and saturation word %0d", k));
    end
  endtask

  task automatic test_run_protocol();
    fill_random();
    build_expected();
    run_engine(1'b1);
    compare_results("run with second start");
    check_quiet(RUN_CYCLES, "strobes after done");  // no hidden second run
    fill_random();
    build_expected();
    run_engine(1'b0);
    compare_results("follow-up run");
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, the engine never finished the tests", WATCHDOG_NS);
    $display("TESTBENCH FAILED");
    $finish;
  end

  initial begin
    seed       = 32'h41ff_661d;
    clk        = 1'b0;
    rst        = 1'b1;
    i_start    = 1'b0;
    act_rdata  = '0;
    wgt_rdata  = '0;
    act_rd_q   = 1'b0;
    wgt_rd_q   = 1'b0;
    act_addr_q = '0;
    wgt_addr_q = '0;
    prev_wr    = 1'b0;
    prev_addr  = '0;
    prev_done  = 1'b0;
    wr_count   = 0;
    done_count = 0;
    wr_mask    = '0;
    value_errs = 0;
    proto_errs = 0;
    check_quiet(RESET_CYC, "strobes during reset");
    rst = 1'b0;
    check_quiet(8, "strobes in idle");
    test_known_pattern();
    test_random_data();
    test_sign_saturation();
    test_run_protocol();
    $display("errors: %0d value, %0d protocol", value_errs, proto_errs);
    if (value_errs + proto_errs == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/cnn_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_ctrl (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_start,
  input  cnn_pkg::word_t      i_res_word,
  output cnn_pkg::bram_req_t  o_act_req,
  output cnn_pkg::bram_req_t  o_wgt_req,
  output cnn_pkg::bram_req_t  o_res_req,
  output cnn_pkg::fill_t      o_fill,
  output cnn_pkg::tile_req_t  o_tile,
  output logic                o_pool_take,
  output logic                o_pool_group,
  output logic [1:0]          o_res_idx,
  output logic                o_done
);

  cnn_pkg::ctrl_state_t state, state_nxt;
  logic [5:0] cnt;    // cycle within the current phase
  logic       group;
  logic       last;   // final cycle of the phase
  logic       act_rd;
  logic       wgt_rd;
  logic       res_wr;

  always_comb begin
    case (state)
      cnn_pkg::LOAD:  last = (cnt == 6'(cnn_pkg::WGT_WORDS));  // one extra cycle for the last fill
      cnn_pkg::TILE:  last = (cnt == 6'(cnn_pkg::POOL_SIZE - 1));
      cnn_pkg::DRAIN: last = (cnt == 6'd1);  // cache + pe register stages
      cnn_pkg::WRITE: last = (cnt == 6'(cnn_pkg::RES_WORDS - 1));
      default:        last = 1'b1;
    endcase
  end

  always_comb begin
    state_nxt = state;
    case (state)
      cnn_pkg::IDLE:  if (i_start) state_nxt = cnn_pkg::LOAD;
      cnn_pkg::LOAD:  if (last) state_nxt = cnn_pkg::TILE;
      cnn_pkg::TILE:  if (last) state_nxt = cnn_pkg::DRAIN;
      cnn_pkg::DRAIN: if (last) state_nxt = cnn_pkg::POOL;
      cnn_pkg::POOL:  state_nxt = group ? cnn_pkg::WRITE : cnn_pkg::TILE;
      cnn_pkg::WRITE: if (last) state_nxt = cnn_pkg::DONE;
      cnn_pkg::DONE:  state_nxt = cnn_pkg::IDLE;
      default:        state_nxt = cnn_pkg::IDLE;
    endcase
  end

  assign act_rd = (state == cnn_pkg::LOAD) && (cnt < 6'(cnn_pkg::ACT_WORDS));
  assign wgt_rd = (state == cnn_pkg::LOAD) && (cnt < 6'(cnn_pkg::WGT_WORDS));
  assign res_wr = (state == cnn_pkg::WRITE);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state  <= cnn_pkg::IDLE;
      cnt    <= '0;
      group  <= 1'b0;
      o_fill <= '0;
    end else begin
      state <= state_nxt;
      cnt   <= last ? '0 : cnt + 6'd1;
      if (state == cnn_pkg::IDLE) begin
        group <= 1'b0;
      end else if (state == cnn_pkg::POOL) begin
        group <= 1'b1;  // second column pair next
      end
      o_fill.act_wr <= act_rd;  // read data lands a cycle later
      o_fill.wgt_wr <= wgt_rd;
      o_fill.idx    <= cnt;
    end
  end

  always_comb begin
    o_act_req       = '0;
    o_act_req.en    = act_rd;
    o_act_req.addr  = cnn_pkg::addr_t'(cnt);
    o_wgt_req       = '0;
    o_wgt_req.en    = wgt_rd;
    o_wgt_req.addr  = cnn_pkg::addr_t'(cnt);
    o_res_req.en    = res_wr;
    o_res_req.we    = {4{res_wr}};
    o_res_req.addr  = cnn_pkg::addr_t'(cnt);
    o_res_req.wdata = i_res_word;
  end

  assign o_tile.valid = (state == cnn_pkg::TILE);
  assign o_tile.group = group;
  assign o_tile.tile  = cnt[1:0];  // 0,1,2,3 -> window tiles 0,1,8,9 order
  assign o_pool_take  = (state == cnn_pkg::POOL);
  assign o_pool_group = group;
  assign o_res_idx    = cnt[1:0];
  assign o_done       = (state == cnn_pkg::DONE);

  // done follows the write of the last result word and drops right away
  a_done_pulse: assert property (@(posedge clk) disable iff (rst)
    o_done |-> $past(o_res_req.en && o_res_req.addr == cnn_pkg::addr_t'(cnn_pkg::RES_WORDS - 1))
    ##1 !o_done);

  a_res_we_en: assert property (@(posedge clk) disable iff (rst)
    (|o_res_req.we) |-> o_res_req.en && o_res_req.addr < cnn_pkg::addr_t'(cnn_pkg::RES_WORDS));

endmodule

`default_nettype wire

// File: hdl/cnn_top.sv
`timescale 1ns/1ps
`default_nettype none

module cnn_top (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_start,
  input  cnn_pkg::word_t        i_act_rdata,
  input  cnn_pkg::word_t        i_wgt_rdata,
  output cnn_pkg::bram_req_t    o_act_req,
  output cnn_pkg::bram_req_t    o_wgt_req,
  output cnn_pkg::bram_req_t    o_res_req,
  output logic                  o_done
);

  cnn_pkg::fill_t                                             fill;
  cnn_pkg::tile_req_t                                         tile;
  cnn_pkg::patch_t                                            patch;
  cnn_pkg::wgt_t [cnn_pkg::NUM_CH*cnn_pkg::KERNEL_TAPS-1:0]   weights;
  cnn_pkg::pe_res_t [cnn_pkg::NUM_CH-1:0]                     pe_res;
  logic                                                       pool_take;
  logic                                                       pool_group;
  logic [1:0]                                                 res_idx;
  cnn_pkg::word_t                                             res_word;

  cnn_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .i_start      (i_start),
    .i_res_word   (res_word),
    .o_act_req    (o_act_req),
    .o_wgt_req    (o_wgt_req),
    .o_res_req    (o_res_req),
    .o_fill       (fill),
    .o_tile       (tile),
    .o_pool_take  (pool_take),
    .o_pool_group (pool_group),
    .o_res_idx    (res_idx),
    .o_done       (o_done)
  );

  act_cache u_act_cache (
    .clk     (clk),
    .rst     (rst),
    .i_fill  (fill),
    .i_rdata (i_act_rdata),
    .i_tile  (tile),
    .o_patch (patch)
  );

  weight_cache u_weight_cache (
    .clk       (clk),
    .rst       (rst),
    .i_fill    (fill),
    .i_rdata   (i_wgt_rdata),
    .o_weights (weights)
  );

  // every PE sees the same patch, each with its own kernel slice
  for (genvar ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin : g_pe
    conv_pe u_pe (
      .clk      (clk),
      .rst      (rst),
      .i_patch  (patch),
      .i_kernel (weights[ch*cnn_pkg::KERNEL_TAPS +: cnn_pkg::KERNEL_TAPS]),
      .o_res    (pe_res[ch])
    );
  end

  max_pool u_pool (
    .clk        (clk),
    .rst        (rst),
    .i_res      (pe_res),
    .i_take     (pool_take),
    .i_group    (pool_group),
    .i_word_idx (res_idx),
    .o_word     (res_word)
  );

endmodule

`default_nettype wire

// File: pe/conv_pe.sv
`timescale 1ns/1ps
`default_nettype none

module conv_pe (
  input  logic                                     clk,
  input  logic                                     rst,
  input  cnn_pkg::patch_t                          i_patch,
  input  cnn_pkg::wgt_t [cnn_pkg::KERNEL_TAPS-1:0] i_kernel,
  output cnn_pkg::pe_res_t                         o_res
);

  cnn_pkg::acc_t sum;
  cnn_pkg::acc_t shifted;
  cnn_pkg::act_t q;
  logic          res_vld;
  cnn_pkg::act_t res_q;

  always_comb begin
    sum = '0;
    for (int t = 0; t < cnn_pkg::KERNEL_TAPS; t++) begin
      sum = sum + $signed({1'b0, i_patch.px[t]}) * $signed(i_kernel[t]);  // unsigned act
    end
  end

  // relu, then quantize and saturate to a byte
  always_comb begin
    shifted = sum >>> cnn_pkg::QUANT_SHIFT;
    if (sum[31]) begin
      q = '0;
    end else if (|shifted[31:8]) begin
      q = 8'hff;
    end else begin
      q = shifted[7:0];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_vld <= 1'b0;
    end else begin
      res_vld <= i_patch.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (i_patch.valid) res_q <= q;
  end

  assign o_res.valid = res_vld;
  assign o_res.q     = res_q;

endmodule

`default_nettype wire

// File: pool/max_pool.sv
`timescale 1ns/1ps
`default_nettype none

module max_pool (
  input  logic                                    clk,
  input  logic                                    rst,
  input  cnn_pkg::pe_res_t [cnn_pkg::NUM_CH-1:0]  i_res,
  input  logic                                    i_take,
  input  logic                                    i_group,
  input  logic [1:0]                              i_word_idx,
  output cnn_pkg::word_t                          o_word
);

  cnn_pkg::act_t hist [cnn_pkg::NUM_CH][cnn_pkg::POOL_SIZE];  // newest in slot 0
  cnn_pkg::act_t ch_max [cnn_pkg::NUM_CH];
  cnn_pkg::act_t res_buf [cnn_pkg::RES_WORDS*4];  // group*8 + channel
  logic          any_vld;

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
      if (i_res[ch].valid) begin
        hist[ch][0] <= i_res[ch].q;
        for (int k = 1; k < cnn_pkg::POOL_SIZE; k++) begin
          hist[ch][k] <= hist[ch][k-1];
        end
      end
    end
  end

  // max over the four tiles of the 2x2 group
  always_comb begin
    for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
      ch_max[ch] = hist[ch][0];
      for (int k = 1; k < cnn_pkg::POOL_SIZE; k++) begin
        if (hist[ch][k] > ch_max[ch]) ch_max[ch] = hist[ch][k];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (i_take) begin
      for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
        res_buf[i_group*cnn_pkg::NUM_CH + ch] <= ch_max[ch];
      end
    end
  end

  always_comb begin
    for (int b = 0; b < 4; b++) begin
      o_word[31-8*b -: 8] = res_buf[4*i_word_idx + b];  // lowest byte index on top
    end
  end

  always_comb begin
    any_vld = 1'b0;
    for (int ch = 0; ch < cnn_pkg::NUM_CH; ch++) begin
      any_vld = any_vld | i_res[ch].valid;
    end
  end

  // the controller must let the pe pipeline drain before pooling
  a_take_idle: assert property (@(posedge clk) disable iff (rst)
    i_take |-> !any_vld);

endmodule

`default_nettype wire
